/* common/mon_pkg.sv */
/*
 * UART debug monitor command front end
 * shared widths, character codes, state encoding and control strobes
 */
`default_nettype none

package mon_pkg;

	typedef logic [7:0]  byte_t;      // one received uart character
	typedef logic [3:0]  nibble_t;    // one hex digit value
	typedef logic [31:0] word_t;      // address, data or pc
	typedef logic [3:0]  digit_cnt_t;

	localparam digit_cnt_t WORD_DIGITS = 4'd8;

	// command characters kept by this monitor
	localparam byte_t CHAR_CTRL_C = 8'h03;
	localparam byte_t CHAR_CR     = 8'h0d;
	localparam byte_t CHAR_G      = 8'h67;
	localparam byte_t CHAR_W      = 8'h77;
	localparam byte_t CHAR_R      = 8'h72;
	localparam byte_t CHAR_S      = 8'h73;

	// lower case hex digit ranges
	localparam byte_t CHAR_0 = 8'h30;
	localparam byte_t CHAR_9 = 8'h39;
	localparam byte_t CHAR_A = 8'h61;
	localparam byte_t CHAR_F = 8'h66;

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_DIGIT,
		KIND_GO,
		KIND_WRITE,
		KIND_READ,
		KIND_STOP_SET,
		KIND_QUIT,
		KIND_CR
	} char_kind_e;

	typedef struct packed {
		logic       valid;
		char_kind_e kind;
		nibble_t    nibble;   // only meaningful for digits
	} char_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_GO_ADDR,
		ST_GO_RUN,
		ST_WR_ADDR,
		ST_WR_DATA,
		ST_RD_START,
		ST_RD_END,
		ST_RD_DUMP,
		ST_BP_ADDR
	} cmd_state_e;

	typedef struct packed {
		logic write_address_set;
		logic write_data_en;
		logic read_start_set;
		logic read_end_set;
		logic read_stop;
		logic cpu_start;
		logic quit_cmd;
		logic crlf_in;
	} mon_ctrl_t;

endpackage

`default_nettype wire

/* decode/char_decoder.sv */
/*
 * Character decoder of the UART monitor
 * registers each received byte and sorts it into digit, command, quit or CR
 */
`timescale 1ns/1ps
`default_nettype none

module char_decoder import mon_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  byte_t rout,
	input  logic  rout_en,
	output char_t char_out
);

	byte_t      pdata;
	logic       data_en;
	char_kind_e kind_raw;
	nibble_t    nibble_raw;

	always_ff @(posedge clk) begin
		if (rout_en)
			pdata <= rout;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			data_en <= 1'b0;
		else
			data_en <= rout_en;   // one cycle behind the byte strobe
	end

	always_comb begin
		kind_raw   = KIND_NONE;
		nibble_raw = '0;
		case (pdata) inside
			[CHAR_0:CHAR_9]: begin
				kind_raw   = KIND_DIGIT;
				nibble_raw = pdata[3:0];
			end
			[CHAR_A:CHAR_F]: begin
				kind_raw   = KIND_DIGIT;
				nibble_raw = pdata[3:0] + 4'd9;   // 'a' is 8'h61
			end
			CHAR_G:      kind_raw = KIND_GO;
			CHAR_W:      kind_raw = KIND_WRITE;
			CHAR_R:      kind_raw = KIND_READ;
			CHAR_S:      kind_raw = KIND_STOP_SET;
			CHAR_CTRL_C: kind_raw = KIND_QUIT;
			CHAR_CR:     kind_raw = KIND_CR;
			default:     kind_raw = KIND_NONE;
		endcase
	end

	assign char_out.valid  = data_en;
	assign char_out.kind   = data_en ? kind_raw : KIND_NONE;
	assign char_out.nibble = nibble_raw;

	// downstream blocks decode kind alone, so an idle cycle must look like none
	a_kind_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!char_out.valid |-> char_out.kind == KIND_NONE);

endmodule

`default_nettype wire

/* cmd/hex_word_assembler.sv */
/*
 * Hex word assembler of the UART monitor
 * shifts accepted hex digits into a 32-bit word and pulses word_valid per word
 */
`timescale 1ns/1ps
`default_nettype none

module hex_word_assembler import mon_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  char_t char_in,
	input  logic  digit_accept,
	input  logic  word_restart,
	output word_t word_out,
	output logic  word_valid
);

	word_t      shift_word;
	word_t      shift_next;
	digit_cnt_t digit_cnt;
	logic       digit_set;
	logic       last_digit;

	assign digit_set  = char_in.valid & (char_in.kind == KIND_DIGIT) & digit_accept;
	assign last_digit = digit_set & (digit_cnt == WORD_DIGITS - 4'd1);
	assign shift_next = {shift_word[27:0], char_in.nibble};   // new digit in low nibble

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			shift_word <= '0;
		else if (word_restart)
			shift_word <= '0;
		else if (digit_set)
			shift_word <= shift_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_cnt <= '0;
		end else if (word_restart) begin
			digit_cnt <= '0;
		end else if (digit_set) begin
			if (last_digit)
				digit_cnt <= '0;   // ready for the next word
			else
				digit_cnt <= digit_cnt + 4'd1;
		end
	end

	// last completed word
	always_ff @(posedge clk) begin
		if (last_digit)
			word_out <= shift_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			word_valid <= 1'b0;
		else
			word_valid <= last_digit;
	end

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
		digit_cnt <= WORD_DIGITS);

endmodule

`default_nettype wire

/* cmd/cmd_fsm.sv */
/*
 * Command state machine of the UART monitor
 * tracks g, w, r and s commands and issues the memory-control strobes
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_fsm import mon_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  char_t     char_in,
	input  logic      word_valid,
	input  logic      dump_running,
	input  logic      bp_hit,
	output logic      digit_accept,
	output logic      word_restart,
	output logic      bp_load,
	output mon_ctrl_t ctrl
);

	cmd_state_e state;
	cmd_state_e state_next;
	logic       cmd_quit;
	logic       cmd_cr;
	logic       g_crlf;
	logic       w_crlf;
	logic       r_crlf;
	logic       s_crlf;
	logic [2:0] g_dly;   // go line end to cpu_start

	assign cmd_quit = char_in.valid & (char_in.kind == KIND_QUIT);
	assign cmd_cr   = char_in.valid & (char_in.kind == KIND_CR);

	always_comb begin
		state_next = state;
		if (cmd_quit) begin
			state_next = ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (char_in.valid) begin
						case (char_in.kind)
							KIND_GO:       state_next = ST_GO_ADDR;
							KIND_WRITE:    state_next = ST_WR_ADDR;
							KIND_READ:     state_next = ST_RD_START;
							KIND_STOP_SET: state_next = ST_BP_ADDR;
							default:       state_next = ST_IDLE;
						endcase
					end
				end
				ST_GO_ADDR:  if (word_valid) state_next = ST_GO_RUN;
				ST_GO_RUN:   if (bp_hit) state_next = ST_IDLE;
				ST_WR_ADDR:  if (word_valid) state_next = ST_WR_DATA;
				ST_WR_DATA:  state_next = ST_WR_DATA;   // data stream until quit
				ST_RD_START: if (word_valid) state_next = ST_RD_END;
				ST_RD_END:   if (word_valid) state_next = ST_RD_DUMP;
				ST_RD_DUMP:  if (!dump_running) state_next = ST_IDLE;
				ST_BP_ADDR:  if (word_valid) state_next = ST_IDLE;
				default:     state_next = ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	assign digit_accept = (state == ST_GO_ADDR) | (state == ST_WR_ADDR) | (state == ST_WR_DATA)
		| (state == ST_RD_START) | (state == ST_RD_END) | (state == ST_BP_ADDR);

	// fresh word whenever a digit-taking command starts
	assign word_restart = cmd_quit | ((state == ST_IDLE) & (state_next != ST_IDLE));

	assign bp_load = (state == ST_BP_ADDR) & word_valid;

	assign g_crlf = (state == ST_GO_ADDR) & (state_next == ST_GO_RUN);
	assign w_crlf = (state == ST_WR_ADDR) & (state_next == ST_WR_DATA);
	assign r_crlf = (state == ST_RD_END) & (state_next == ST_RD_DUMP);
	assign s_crlf = (state == ST_BP_ADDR) & word_valid & ~cmd_quit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			g_dly <= '0;
		else
			g_dly <= {g_dly[1:0], g_crlf};
	end

	assign ctrl.write_address_set = (state == ST_WR_ADDR) & word_valid;
	assign ctrl.write_data_en     = (state == ST_WR_DATA) & word_valid;
	assign ctrl.read_start_set    = (state == ST_RD_START) & word_valid;
	assign ctrl.read_end_set      = (state == ST_RD_END) & word_valid;
	assign ctrl.read_stop         = (state == ST_RD_DUMP) & cmd_quit;
	assign ctrl.cpu_start         = g_dly[2];
	assign ctrl.quit_cmd          = cmd_quit | ((state == ST_GO_RUN) & bp_hit);
	assign ctrl.crlf_in           = g_crlf | w_crlf | r_crlf | s_crlf | cmd_quit | cmd_cr;

	a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {ST_IDLE, ST_GO_ADDR, ST_GO_RUN, ST_WR_ADDR, ST_WR_DATA,
			ST_RD_START, ST_RD_END, ST_RD_DUMP, ST_BP_ADDR});

endmodule

`default_nettype wire

/* rtl/break_point.sv */
/*
 * Program breakpoint of the UART monitor
 * holds a word-aligned PC breakpoint and compares it with the running PC
 */
`timescale 1ns/1ps
`default_nettype none

module break_point import mon_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t word_in,
	input  logic  bp_load,
	input  word_t pc_data,
	input  logic  cpu_run_state,
	output logic  bp_hit,
	output logic  bp_match
);

	logic [31:2] bp_addr;
	logic        bp_en;

	always_ff @(posedge clk) begin
		if (bp_load)
			bp_addr <= word_in[31:2];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bp_en <= 1'b0;
		else if (bp_load)
			bp_en <= ~word_in[0];   // odd word switches the breakpoint off
	end

	assign bp_match = bp_en & (bp_addr == pc_data[31:2]);
	assign bp_hit   = bp_match & cpu_run_state;

	a_hit_match: assert property (@(posedge clk) disable iff (!rst_n)
		bp_hit |-> bp_match);

endmodule

`default_nettype wire

/* rtl/uart_monitor_cmd.sv */
/*
 * UART debug monitor command front end
 * decoder, hex word assembler, command FSM and program breakpoint
 */
`timescale 1ns/1ps
`default_nettype none

module uart_monitor_cmd import mon_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  byte_t     rout,
	input  logic      rout_en,
	input  logic      dump_running,
	input  logic      cpu_run_state,
	input  word_t     pc_data,
	output mon_ctrl_t ctrl,
	output word_t     uart_data,
	output logic      bp_match
);

	char_t char_w;
	word_t word_w;
	logic  word_valid;
	logic  digit_accept;
	logic  word_restart;
	logic  bp_load;
	logic  bp_hit;

	char_decoder i_char_decoder (
		.clk      (clk),
		.rst_n    (rst_n),
		.rout     (rout),
		.rout_en  (rout_en),
		.char_out (char_w)
	);

	hex_word_assembler i_hex_word_assembler (
		.clk          (clk),
		.rst_n        (rst_n),
		.char_in      (char_w),
		.digit_accept (digit_accept),
		.word_restart (word_restart),
		.word_out     (word_w),
		.word_valid   (word_valid)
	);

	cmd_fsm i_cmd_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.char_in      (char_w),
		.word_valid   (word_valid),
		.dump_running (dump_running),
		.bp_hit       (bp_hit),
		.digit_accept (digit_accept),
		.word_restart (word_restart),
		.bp_load      (bp_load),
		.ctrl         (ctrl)
	);

	break_point i_break_point (
		.clk           (clk),
		.rst_n         (rst_n),
		.word_in       (word_w),
		.bp_load       (bp_load),
		.pc_data       (pc_data),
		.cpu_run_state (cpu_run_state),
		.bp_hit        (bp_hit),
		.bp_match      (bp_match)
	);

	assign uart_data = word_w;   // address or data for the memory side

endmodule

`default_nettype wire

/* test/tb_uart_monitor_cmd.sv */
/*
 * Testbench of the UART monitor command front end
 * sends command strings byte by byte and checks strobes, words and breakpoint stops
 */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_monitor_cmd import mon_pkg::*; ();

	// one table row of stimulus and expected answers
	typedef struct packed {
		word_t     pc;          // breakpoint address that the run pc steps toward
		logic [7:0] dump_len;   // cycles dump_running stays high after the string
		logic      run;
		logic      bp_seen;
		logic [3:0] n_words;    // words expected on the address strobes
		word_t     exp_cnt;     // one nibble of strobe count per ctrl bit
		mon_ctrl_t first_ctrl;  // ctrl in the first crlf_in cycle
	} entry_t;

	localparam int N_ENTRIES = 9;

	logic      clk = 1'b0;
	logic      rst_n;
	byte_t     rout;
	logic      rout_en;
	logic      dump_running;
	logic      cpu_run_state;
	word_t     pc_data;
	mon_ctrl_t ctrl;
	word_t     uart_data;
	logic      bp_match;

	entry_t tab [N_ENTRIES];
	string  cmd_tab [N_ENTRIES];
	string  tail_tab [N_ENTRIES];

	word_t     lcg_state = 32'h6a6d_b0a5;
	word_t     sent_q [$];
	word_t     got_q [$];
	mon_ctrl_t crlf_q [$];
	int        cnt [8];
	int        cnt_base [8];
	int        bp_cnt;
	int        start_bad;
	logic [2:0] crlf_hist = '0;
	int        errors;
	int        checks;
	int        timeouts;

	uart_monitor_cmd i_uart_monitor_cmd (
		.clk           (clk),
		.rst_n         (rst_n),
		.rout          (rout),
		.rout_en       (rout_en),
		.dump_running  (dump_running),
		.cpu_run_state (cpu_run_state),
		.pc_data       (pc_data),
		.ctrl          (ctrl),
		.uart_data     (uart_data),
		.bp_match      (bp_match)
	);

	always #5 clk = ~clk;

	// strobe monitor sampled on the rising edge
	always @(posedge clk) begin
		logic [7:0] cb;
		cb = ctrl;
		if (rst_n) begin
			for (int b = 0; b < 8; b++)
				if (cb[b]) cnt[b]++;
			if (ctrl.cpu_start && !crlf_hist[2])
				start_bad++;   // cpu_start must trail the go crlf by 3
			crlf_hist = {crlf_hist[1:0], ctrl.crlf_in};
			if (ctrl.write_address_set | ctrl.write_data_en | ctrl.read_start_set
				| ctrl.read_end_set)
				got_q.push_back(uart_data);
			if (ctrl.crlf_in)
				crlf_q.push_back(ctrl);
			if (bp_match)
				bp_cnt++;
		end
	end

	function automatic word_t lcg_next(input word_t s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// counts since the row started with each nibble saturated
	function automatic word_t count_word();
		word_t w;
		int    d;
		w = '0;
		for (int b = 0; b < 8; b++) begin
			d = cnt[b] - cnt_base[b];
			w[4*b +: 4] = (d > 15) ? 4'hf : d[3:0];
		end
		return w;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_ctrl(input string name, input mon_ctrl_t got, input mon_ctrl_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic send_byte(input byte_t b);
		rout    = b;
		rout_en = 1'b1;
		@(negedge clk);
		rout_en = 1'b0;
		repeat (3) @(negedge clk);   // idle gap
	endtask

	task automatic send_word(input word_t w, input logic noisy);
		nibble_t nib;
		for (int i = 7; i >= 0; i--) begin
			nib = w[4*i +: 4];
			send_byte(nib < 4'd10 ? 8'h30 + {4'h0, nib} : 8'h57 + {4'h0, nib});
			if (noisy && (i == 5 || i == 2))
				send_byte(i == 5 ? 8'h78 : 8'h2d);   // 'x' and '-'
		end
	endtask

	// # random word, * random word with junk bytes, P/Q breakpoint even/odd,
	// ^ ctrl-c, ! carriage return
	task automatic send_string(input string s, input word_t pc);
		byte_t c;
		for (int i = 0; i < s.len(); i++) begin
			c = s[i];
			case (c)
				"#", "*": begin
					lcg_state = lcg_next(lcg_state);
					sent_q.push_back(lcg_state);
					send_word(lcg_state, c == "*");
				end
				"P":     send_word(pc, 1'b0);
				"Q":     send_word(pc | 32'd1, 1'b0);
				"^":     send_byte(8'h03);
				"!":     send_byte(8'h0d);
				default: send_byte(c);
			endcase
		end
	endtask

	task automatic run_cpu(input logic expect_hit);
		int q0;
		int n;
		q0 = cnt[1];
		n  = 0;
		cpu_run_state = 1'b1;
		while (cnt[1] == q0 && n < 16) begin
			@(negedge clk);
			if (cnt[1] == q0)
				pc_data = pc_data + 32'd4;
			n++;
		end
		cpu_run_state = 1'b0;
		pc_data       = '0;
		if (expect_hit && cnt[1] == q0) begin
			timeouts++;
			$display("timeout: the breakpoint never stopped the running CPU");
		end
	endtask

	task automatic wait_counts(input word_t exp);
		int n;
		n = 0;
		while (count_word() != exp && n < 80) begin
			@(negedge clk);
			n++;
		end
		if (count_word() != exp) begin
			timeouts++;
			$display("timeout: strobe counts did not settle within 80 cycles");
		end
	endtask

	task automatic load_table();
		cmd_tab[0] = "w####^";
		cmd_tab[1] = "r##";
		cmd_tab[2] = "w#^";
		cmd_tab[3] = "r##^";
		cmd_tab[4] = "g#^";
		cmd_tab[5] = "sPg#";
		cmd_tab[6] = "sQg#";
		cmd_tab[7] = "w*^";
		cmd_tab[8] = "!";
		tail_tab[6] = "^";   // quit after the run
		tab[0] = '{32'h0, 8'd0, 1'b0, 1'b0, 4'd4, 32'h1300_0012, mon_ctrl_t'(8'h81)};
		tab[1] = '{32'h0, 8'd20, 1'b0, 1'b0, 4'd2, 32'h0011_0001, mon_ctrl_t'(8'h11)};
		tab[2] = '{32'h0, 8'd0, 1'b0, 1'b0, 4'd1, 32'h1000_0012, mon_ctrl_t'(8'h81)};
		tab[3] = '{32'h0, 8'd10, 1'b0, 1'b0, 4'd2, 32'h0011_1012, mon_ctrl_t'(8'h11)};
		tab[4] = '{32'h0, 8'd0, 1'b0, 1'b0, 4'd0, 32'h0000_0112, mon_ctrl_t'(8'h01)};
		tab[5] = '{32'h1a40, 8'd0, 1'b1, 1'b1, 4'd0, 32'h0000_0112, mon_ctrl_t'(8'h01)};
		tab[6] = '{32'h1a40, 8'd0, 1'b1, 1'b0, 4'd0, 32'h0000_0113, mon_ctrl_t'(8'h01)};
		tab[7] = '{32'h0, 8'd0, 1'b0, 1'b0, 4'd1, 32'h1000_0012, mon_ctrl_t'(8'h81)};
		tab[8] = '{32'h0, 8'd0, 1'b0, 1'b0, 4'd0, 32'h0000_0001, mon_ctrl_t'(8'h01)};
	endtask

	initial begin
		int wbase;
		int sbase;
		int cbase;
		int bp_base;
		int sbad_base;
		rst_n         = 1'b0;
		rout          = '0;
		rout_en       = 1'b0;
		dump_running  = 1'b0;
		cpu_run_state = 1'b0;
		pc_data       = '0;
		errors        = 0;
		checks        = 0;
		timeouts      = 0;
		load_table();
		repeat (2) @(negedge clk);
		check_ctrl("ctrl in reset", ctrl, '0);
		check_bit("bp_match in reset", bp_match, 1'b0);
		rst_n = 1'b1;
		@(negedge clk);

		for (int e = 0; e < N_ENTRIES; e++) begin
			for (int b = 0; b < 8; b++)
				cnt_base[b] = cnt[b];
			wbase     = got_q.size();
			sbase     = sent_q.size();
			cbase     = crlf_q.size();
			bp_base   = bp_cnt;
			sbad_base = start_bad;
			pc_data      = tab[e].pc - 32'd16;
			dump_running = (tab[e].dump_len != 8'd0);
			send_string(cmd_tab[e], tab[e].pc);
			repeat (tab[e].dump_len) @(negedge clk);
			dump_running = 1'b0;
			if (tab[e].run)
				run_cpu(tab[e].bp_seen);
			send_string(tail_tab[e], tab[e].pc);
			wait_counts(tab[e].exp_cnt);

			check_word("strobe counts", count_word(), tab[e].exp_cnt);
			check_word("strobed word count", word_t'(got_q.size() - wbase),
				word_t'(tab[e].n_words));
			for (int k = 0; k < int'(tab[e].n_words); k++)
				if (wbase + k < got_q.size())
					check_word("uart_data", got_q[wbase + k], sent_q[sbase + k]);
			if (crlf_q.size() > cbase) begin
				check_ctrl("ctrl at first crlf_in", crlf_q[cbase], tab[e].first_ctrl);
			end else begin
				errors++;
				$display("row %0d gave no crlf_in pulse at all", e);
			end
			check_bit("bp_match", bp_cnt != bp_base, tab[e].bp_seen);
			check_bit("cpu_start delay", start_bad == sbad_base, 1'b1);
			check_ctrl("ctrl", ctrl, '0);   // quiet between commands
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
common/mon_pkg.sv
decode/char_decoder.sv
cmd/hex_word_assembler.sv
cmd/cmd_fsm.sv
rtl/break_point.sv
rtl/uart_monitor_cmd.sv
test/tb_uart_monitor_cmd.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the UART monitor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f \
	--top-module tb_uart_monitor_cmd -o tb_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
exit 1
